// File: hw/floor_ctl_settings.svh
/*
 * Build-time constants of the floor request controller.
 * Included by the package, every RTL module and the testbench files.
 */

`ifndef FLOOR_CTL_SETTINGS_SVH
`define FLOOR_CTL_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Building size
//////////////////////////////////////////////////////////////////////

// Number of served floors, one button and one light per floor
`define FLOOR_COUNT 11

// Bits needed to code a floor number
`define FLOOR_BITS 4

//////////////////////////////////////////////////////////////////////
// Fixed values
//////////////////////////////////////////////////////////////////////

// All request lights dark
`define LIGHTS_OFF {`FLOOR_COUNT{1'b0}}

`endif

// File: hw/floor_ctl_pkg.sv
/*
 * Shared types of the floor request controller.
 * Imported by wildcard in the header of each module that needs them.
 */

`include "floor_ctl_settings.svh"

package floor_ctl_pkg;

    // Floor code, bottom floor is zero
    typedef enum logic [`FLOOR_BITS-1:0] {
        FLOOR_1  = 0,
        FLOOR_2  = 1,
        FLOOR_3  = 2,
        FLOOR_4  = 3,
        FLOOR_5  = 4,
        FLOOR_6  = 5,
        FLOOR_7  = 6,
        FLOOR_8  = 7,
        FLOOR_9  = 8,
        FLOOR_10 = 9,
        FLOOR_11 = 10
    } floor_t;

    // Travel direction handed to the car FSM
    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } dir_t;

endpackage

// File: hw/request_bank.sv
/*
 * One bank of request lights, used once for hall calls and once for the car panel.
 * Latches at most one new press per clock and clears the light of a floor on arrival.
 */

`include "floor_ctl_settings.svh"
`timescale 1ns/1ns

module request_bank
    import floor_ctl_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic [`FLOOR_COUNT-1:0] buttons,
    input  floor_t                  current_floor,
    input  logic                    elevator_moving,
    input  logic                    power_switch,
    input  logic                    emergency_btn,
    output logic [`FLOOR_COUNT-1:0] lights
);

    // One-hot view of the floor the car stands at
    logic [`FLOOR_COUNT-1:0] floor_onehot;

    // Presses that may still become a new light
    logic [`FLOOR_COUNT-1:0] eligible;

    // Single light chosen this cycle
    logic [`FLOOR_COUNT-1:0] new_press;
    logic                    press_found;

    // Light to drop because the car is stopped at its floor
    logic [`FLOOR_COUNT-1:0] arrive_clear;

    logic [`FLOOR_COUNT-1:0] next_lights;
    logic                    update_en;

    //////////////////////////////////////////////////////////////////////
    // Request selection
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            floor_onehot[i] = (current_floor == floor_t'(i));
        end
    end

    // A press for the current floor is refused, a lit floor needs no new press
    assign eligible = buttons & ~lights & ~floor_onehot;

    // Priority search, lowest floor wins
    always_comb begin
        new_press   = `LIGHTS_OFF;
        press_found = 1'b0;
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            if (eligible[i] && !press_found) begin
                new_press[i] = 1'b1;
                press_found  = 1'b1;
            end
        end
    end

    // Clearing only happens while the car is standing still
    assign arrive_clear = elevator_moving ? `LIGHTS_OFF : floor_onehot;

    assign next_lights = (lights | new_press) & ~arrive_clear;

    //////////////////////////////////////////////////////////////////////
    // Light register
    //////////////////////////////////////////////////////////////////////

    // Power off or emergency freezes the whole bank
    assign update_en = power_switch && !emergency_btn;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= `LIGHTS_OFF;
        end else if (update_en) begin
            lights <= next_lights;
        end
    end

endmodule

// File: hw/car_dispatch.sv
/*
 * Dispatch stage, turns the two light banks into a target floor and a travel request.
 * Purely combinational, also gates the door buttons into door permits.
 */

`include "floor_ctl_settings.svh"
`timescale 1ns/1ns

module car_dispatch
    import floor_ctl_pkg::*;
(
    input  logic [`FLOOR_COUNT-1:0] call_button_lights,
    input  logic [`FLOOR_COUNT-1:0] panel_button_lights,
    input  floor_t                  current_floor,
    input  logic                    elevator_moving,
    input  logic                    power_switch,
    input  logic                    emergency_btn,
    input  logic                    door_open_btn,
    input  logic                    door_close_btn,
    output floor_t                  elevator_floor_selector,
    output dir_t                    direction_selector,
    output logic                    activate_elevator,
    output logic                    door_open_allowed,
    output logic                    door_close_allowed
);

    // Hall and car requests count alike
    logic [`FLOOR_COUNT-1:0] merged_lights;

    floor_t lowest_lit;
    logic   lit_found;

    // Car is standing still with power on
    logic   stopped_powered;

    //////////////////////////////////////////////////////////////////////
    // Target selection
    //////////////////////////////////////////////////////////////////////

    assign merged_lights = call_button_lights | panel_button_lights;

    // Priority encoder, the lowest lit floor is served first
    always_comb begin
        // With nothing lit the car simply stays where it is
        lowest_lit = current_floor;
        lit_found  = 1'b0;
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            if (merged_lights[i] && !lit_found) begin
                lowest_lit = floor_t'(i);
                lit_found  = 1'b1;
            end
        end
    end

    assign elevator_floor_selector = lowest_lit;

    //////////////////////////////////////////////////////////////////////
    // Travel request
    //////////////////////////////////////////////////////////////////////

    assign activate_elevator = power_switch && !emergency_btn && !elevator_moving &&
                               (elevator_floor_selector != current_floor);

    // Equal floors fall to DIR_DOWN, activate is low then anyway
    assign direction_selector = (elevator_floor_selector > current_floor) ? DIR_UP : DIR_DOWN;

    //////////////////////////////////////////////////////////////////////
    // Door permits
    //////////////////////////////////////////////////////////////////////

    assign stopped_powered = power_switch && !elevator_moving;

    assign door_open_allowed  = stopped_powered && door_open_btn;
    assign door_close_allowed = stopped_powered && door_close_btn;

endmodule

// File: hw/floor_ctl_top.sv
/*
 * Top level of the floor request controller.
 * Hall bank and car bank run side by side and feed the dispatch stage.
 */

`include "floor_ctl_settings.svh"
`timescale 1ns/1ns

module floor_ctl_top
    import floor_ctl_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic [`FLOOR_COUNT-1:0] floor_call_buttons,
    input  logic [`FLOOR_COUNT-1:0] panel_buttons,
    input  logic                    door_open_btn,
    input  logic                    door_close_btn,
    input  logic                    emergency_btn,
    input  logic                    power_switch,
    input  floor_t                  current_floor,
    input  logic                    elevator_moving,
    output floor_t                  elevator_floor_selector,
    output dir_t                    direction_selector,
    output logic                    activate_elevator,
    output logic                    door_open_allowed,
    output logic                    door_close_allowed,
    output logic [`FLOOR_COUNT-1:0] call_button_lights,
    output logic [`FLOOR_COUNT-1:0] panel_button_lights
);

    // Hall call buttons outside the car
    request_bank hall_bank0 (
        .clock           (clock),
        .reset_n         (reset_n),
        .buttons         (floor_call_buttons),
        .current_floor   (current_floor),
        .elevator_moving (elevator_moving),
        .power_switch    (power_switch),
        .emergency_btn   (emergency_btn),
        .lights          (call_button_lights)
    );

    // Destination buttons on the car panel
    request_bank car_bank0 (
        .clock           (clock),
        .reset_n         (reset_n),
        .buttons         (panel_buttons),
        .current_floor   (current_floor),
        .elevator_moving (elevator_moving),
        .power_switch    (power_switch),
        .emergency_btn   (emergency_btn),
        .lights          (panel_button_lights)
    );

    car_dispatch dispatch0 (
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .power_switch            (power_switch),
        .emergency_btn           (emergency_btn),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

endmodule

// File: dv/floor_ctl_chk.sv
/*
 * Concurrent properties on the floor controller top level.
 * Attached to floor_ctl_top by a bind statement in the testbench.
 */

`include "floor_ctl_settings.svh"
`timescale 1ns/1ns

module floor_ctl_chk (
    input logic                    clock,
    input logic                    reset_n,
    input logic                    elevator_moving,
    input logic                    power_switch,
    input logic                    activate_elevator,
    input logic                    door_open_allowed,
    input logic                    door_close_allowed,
    input logic [`FLOOR_COUNT-1:0] call_button_lights,
    input logic [`FLOOR_COUNT-1:0] panel_button_lights
);

    // Number of failed properties
    int assert_fail_count = 0;

    // A moving car never gets a new travel request
    no_activate_while_moving: assert property (
        @(posedge clock) disable iff (!reset_n)
        elevator_moving |-> !activate_elevator
    ) else begin
        assert_fail_count++;
        $error("activate_elevator high while the car is moving");
    end

    // Doors stay shut without power
    no_doors_without_power: assert property (
        @(posedge clock) disable iff (!reset_n)
        !power_switch |-> (!door_open_allowed && !door_close_allowed)
    ) else begin
        assert_fail_count++;
        $error("door permit given while power is off");
    end

    // First edge after reset release sees dark banks
    lights_dark_after_reset: assert property (
        @(posedge clock)
        $rose(reset_n) |-> (call_button_lights == '0 && panel_button_lights == '0)
    ) else begin
        assert_fail_count++;
        $error("request lights not dark after reset");
    end

endmodule

// File: dv/floor_ctl_monitor.sv
/*
 * Checker of the floor controller testbench, holds its own model of both light banks.
 * Compares every DUT output at each rising edge and counts the mismatches.
 */

`include "floor_ctl_settings.svh"
`timescale 1ns/1ns

module floor_ctl_monitor
    import floor_ctl_pkg::*;
(
    input logic                    clock,
    input logic                    reset_n,
    input logic [`FLOOR_COUNT-1:0] floor_call_buttons,
    input logic [`FLOOR_COUNT-1:0] panel_buttons,
    input logic                    door_open_btn,
    input logic                    door_close_btn,
    input logic                    emergency_btn,
    input logic                    power_switch,
    input floor_t                  current_floor,
    input logic                    elevator_moving,
    input floor_t                  elevator_floor_selector,
    input dir_t                    direction_selector,
    input logic                    activate_elevator,
    input logic                    door_open_allowed,
    input logic                    door_close_allowed,
    input logic [`FLOOR_COUNT-1:0] call_button_lights,
    input logic [`FLOOR_COUNT-1:0] panel_button_lights
);

    int error_count = 0;

    logic [`FLOOR_COUNT-1:0] hall_model;
    logic [`FLOOR_COUNT-1:0] car_model;

    // Packed as {target[3:0], up, activate, open, close}
    logic [7:0] exp_dispatch;

    //////////////////////////////////////////////////////////////////////
    // Reference rules
    //////////////////////////////////////////////////////////////////////

    function automatic logic [`FLOOR_COUNT-1:0] bank_ref(
        input logic [`FLOOR_COUNT-1:0] lights,
        input logic [`FLOOR_COUNT-1:0] buttons,
        input int                      floor,
        input logic                    moving,
        input logic                    power,
        input logic                    emergency
    );
        logic [`FLOOR_COUNT-1:0] result;
        logic                    taken;
        result = lights;
        taken  = 1'b0;
        if (power && !emergency) begin
            for (int i = 0; i < `FLOOR_COUNT; i++) begin
                if (!taken && buttons[i] && !lights[i] && i != floor) begin
                    result[i] = 1'b1;
                    taken     = 1'b1;
                end
            end
            if (!moving)
                result[floor] = 1'b0;
        end
        return result;
    endfunction

    function automatic logic [7:0] dispatch_ref(
        input logic [`FLOOR_COUNT-1:0] hall,
        input logic [`FLOOR_COUNT-1:0] car,
        input int                      floor,
        input logic                    moving,
        input logic                    power,
        input logic                    emergency,
        input logic                    open_btn,
        input logic                    close_btn
    );
        int   target;
        logic up;
        logic act;
        logic doors_ok;
        target = floor;
        // Walking down leaves the lowest lit floor as the last hit
        for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
            if (hall[i] || car[i])
                target = i;
        end
        up       = target > floor;
        act      = power && !emergency && !moving && (target != floor);
        doors_ok = power && !moving;
        return {target[3:0], up, act, doors_ok && open_btn, doors_ok && close_btn};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Model and compare
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string signal, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("error %s %s: expected %0h actual %0h",
                     floor_ctl_tb.test_name, signal, expected, actual);
        end
    endtask

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            hall_model <= `LIGHTS_OFF;
            car_model  <= `LIGHTS_OFF;
        end else begin
            hall_model <= bank_ref(hall_model, floor_call_buttons, int'(current_floor),
                                   elevator_moving, power_switch, emergency_btn);
            car_model  <= bank_ref(car_model, panel_buttons, int'(current_floor),
                                   elevator_moving, power_switch, emergency_btn);
        end
    end

    // Outputs seen here still belong to the cycle that ends at this edge
    always @(posedge clock) begin
        exp_dispatch = dispatch_ref(hall_model, car_model, int'(current_floor),
                                    elevator_moving, power_switch, emergency_btn,
                                    door_open_btn, door_close_btn);
        check_value("call_button_lights", hall_model, call_button_lights);
        check_value("panel_button_lights", car_model, panel_button_lights);
        check_value("elevator_floor_selector", exp_dispatch[7:4], elevator_floor_selector);
        check_value("direction_selector", exp_dispatch[3], direction_selector);
        check_value("activate_elevator", exp_dispatch[2], activate_elevator);
        check_value("door_open_allowed", exp_dispatch[1], door_open_allowed);
        check_value("door_close_allowed", exp_dispatch[0], door_close_allowed);
    end

endmodule

// File: dv/floor_ctl_tb.sv
/*
 * Testbench top for the floor request controller.
 * Runs directed phases and a random run, the monitor instance does all comparing.
 */

`include "floor_ctl_settings.svh"
`timescale 1ns/1ns

module floor_ctl_tb
    import floor_ctl_pkg::*;
();

    localparam int RESET_CYCLES    = 8;
    localparam int DIRECTED_CYCLES = 150;
    localparam int RANDOM_CYCLES   = 400;
    localparam int MARGIN_CYCLES   = 50;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES +
                                     MARGIN_CYCLES;

    logic                    clock;
    logic                    reset_n;
    logic [`FLOOR_COUNT-1:0] floor_call_buttons;
    logic [`FLOOR_COUNT-1:0] panel_buttons;
    logic                    door_open_btn;
    logic                    door_close_btn;
    logic                    emergency_btn;
    logic                    power_switch;
    floor_t                  current_floor;
    logic                    elevator_moving;
    floor_t                  elevator_floor_selector;
    dir_t                    direction_selector;
    logic                    activate_elevator;
    logic                    door_open_allowed;
    logic                    door_close_allowed;
    logic [`FLOOR_COUNT-1:0] call_button_lights;
    logic [`FLOOR_COUNT-1:0] panel_button_lights;

    string test_name;
    int    seed;
    int    timeout_count = 0;

    floor_ctl_top dut0 (.*);

    floor_ctl_monitor mon0 (.*);

    bind floor_ctl_top floor_ctl_chk chk0 (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers, all changes land on the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic wait_cycles(input int cycles);
        repeat (cycles) @(negedge clock);
    endtask

    task automatic place_car(input floor_t floor, input logic moving);
        @(negedge clock);
        current_floor   = floor;
        elevator_moving = moving;
    endtask

    task automatic hold_buttons(input logic [`FLOOR_COUNT-1:0] hall,
                                input logic [`FLOOR_COUNT-1:0] car, input int cycles);
        @(negedge clock);
        floor_call_buttons = hall;
        panel_buttons      = car;
        repeat (cycles) @(negedge clock);
        floor_call_buttons = `LIGHTS_OFF;
        panel_buttons      = `LIGHTS_OFF;
    endtask

    task automatic finish_run();
        int total;
        total = mon0.error_count + dut0.chk0.assert_fail_count + timeout_count;
        $display("Summary: %0d output mismatches, %0d assertion failures, %0d timeouts",
                 mon0.error_count, dut0.chk0.assert_fail_count, timeout_count);
        if (total == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test phases
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed               = 13;
        test_name          = "reset";
        reset_n            = 1'b0;
        floor_call_buttons = `LIGHTS_OFF;
        panel_buttons      = `LIGHTS_OFF;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        current_floor      = FLOOR_1;
        elevator_moving    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        wait_cycles(3);

        test_name = "single_press_up";
        place_car(FLOOR_3, 1'b0);
        hold_buttons(`LIGHTS_OFF, 11'b1 << 7, 1);
        wait_cycles(2);
        place_car(FLOOR_8, 1'b0);
        wait_cycles(2);

        test_name = "single_press_down";
        hold_buttons(`LIGHTS_OFF, 11'b1 << 1, 1);
        wait_cycles(2);
        place_car(FLOOR_2, 1'b0);
        wait_cycles(2);

        test_name = "refuse_current";
        hold_buttons(11'b1 << 1, 11'b1 << 1, 2);
        wait_cycles(2);

        // Hall and panel overlap at floor 6
        test_name = "multi_press";
        place_car(FLOOR_11, 1'b0);
        hold_buttons(11'b010_0010_0100, 11'b000_1010_1000, 4);
        wait_cycles(2);

        test_name = "moving_hold";
        place_car(FLOOR_6, 1'b1);
        wait_cycles(2);
        hold_buttons(11'b000_0000_0001, `LIGHTS_OFF, 1);
        wait_cycles(2);

        test_name = "arrival_clear";
        place_car(FLOOR_6, 1'b0);
        wait_cycles(2);
        for (int f = 0; f < `FLOOR_COUNT; f++) begin
            place_car(floor_t'(f), 1'b0);
        end
        wait_cycles(2);

        test_name = "power_off";
        @(negedge clock);
        power_switch  = 1'b0;
        door_open_btn = 1'b1;
        hold_buttons({`FLOOR_COUNT{1'b1}}, {`FLOOR_COUNT{1'b1}}, 2);
        @(negedge clock);
        power_switch   = 1'b1;
        door_close_btn = 1'b1;
        wait_cycles(1);
        place_car(FLOOR_4, 1'b1);
        wait_cycles(2);
        place_car(FLOOR_4, 1'b0);
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
        wait_cycles(1);

        test_name = "emergency";
        @(negedge clock);
        emergency_btn = 1'b1;
        hold_buttons(11'b100_0000_0001, 11'b010_0000_0010, 2);
        @(negedge clock);
        emergency_btn = 1'b0;
        wait_cycles(2);

        test_name = "random";
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            @(negedge clock);
            floor_call_buttons = `FLOOR_COUNT'($random(seed) & $random(seed));
            panel_buttons      = `FLOOR_COUNT'($random(seed) & $random(seed));
            current_floor      = floor_t'($unsigned($random(seed)) % `FLOOR_COUNT);
            elevator_moving    = ($random(seed) & 3) == 0;
            power_switch       = ($random(seed) & 7) != 0;
            emergency_btn      = ($random(seed) & 15) == 0;
            door_open_btn      = $random(seed) & 1;
            door_close_btn     = $random(seed) & 1;
        end
        wait_cycles(2);

        finish_run();
    end

    // Watchdog sized from the phase lengths above
    initial begin
        #(TOTAL_CYCLES * 8);
        timeout_count++;
        $display("Run timed out in test %s before all phases finished", test_name);
        finish_run();
    end

endmodule

// File: floor_ctl.f
+incdir+hw
hw/floor_ctl_pkg.sv
hw/request_bank.sv
hw/car_dispatch.sv
hw/floor_ctl_top.sv
dv/floor_ctl_chk.sv
dv/floor_ctl_monitor.sv
dv/floor_ctl_tb.sv
